// ==== logic/posit_config.svh ====
`ifndef POSIT_CONFIG_SVH
`define POSIT_CONFIG_SVH

//////////////////////////////////////////////////
// Posit format sizing
//////////////////////////////////////////////////

`define POSIT_N  32 // Word width
`define POSIT_ES 2  // Exponent field width
`define POSIT_BS 5  // Regime count width, log2 of word

`endif

// ==== logic/posit_pkg.sv ====
`include "posit_config.svh"

// Number format types
package posit_pkg;

	//////////////////////////////////////////////////
	// Raw word
	//////////////////////////////////////////////////

	typedef logic [`POSIT_N-1:0] posit_t;

	//////////////////////////////////////////////////
	// One operand after decoding
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                   sign;   // Word MSB
		logic                   nar;    // 0x80000000
		logic                   zero;   // All zero
		logic                   rpos;   // Run of ones, regime >= 0
		logic [`POSIT_BS-1:0]   regime; // Magnitude of k
		logic [`POSIT_ES-1:0]   exp;
		logic [`POSIT_N-`POSIT_ES:0] mant; // Hidden bit on top
	} posit_dec_t;

endpackage

// ==== logic/posit_mult_pkg.sv ====
`include "posit_config.svh"

// Multiplier datapath types
package posit_mult_pkg;

	// Combined scale 4*k + e, both operands summed
	typedef logic signed [`POSIT_BS+`POSIT_ES+1:0] scale_t;

	//////////////////////////////////////////////////
	// Mantissa product plus scale
	//////////////////////////////////////////////////

	typedef struct packed {
		logic   sign;  // XOR of operand signs
		logic   nar;   // Either operand NaR
		logic   zero;  // Both operands zero
		logic   norm;  // Clear when a zero operand killed the product
		scale_t scale;
		logic [2*(`POSIT_N-`POSIT_ES+1)-1:0] mant; // MSB is the hidden one
	} prod_t;

	//////////////////////////////////////////////////
	// Encoded result, what the output bank holds
	//////////////////////////////////////////////////

	typedef struct packed {
		posit_pkg::posit_t word;
		logic              nar;
		logic              zero;
	} mult_out_t;

endpackage

// ==== logic/posit_lod.sv ====
`timescale 1ns/1ps

// Leading-one detector tree
// Position counted from the MSB, so an MSB hit gives 0
module posit_lod #(
	parameter int W = 32 // Power of two, 2 or more
) (
	input  logic [W-1:0]         in_i,
	output logic [$clog2(W)-1:0] pos_o,
	output logic                 vld_o  // Any bit set
);

	generate
		if (W == 2) begin : g_leaf
			assign vld_o = |in_i;
			assign pos_o = ~in_i[1] & in_i[0]; // 1 only when MSB clear
		end else begin : g_node
			localparam int SW = $clog2(W) - 1; // Child position width
			logic [SW-1:0] pos_hi;
			logic [SW-1:0] pos_lo;
			logic          vld_hi;
			logic          vld_lo;

			posit_lod #(.W(W/2)) u_hi (.in_i(in_i[W-1:W/2]), .pos_o(pos_hi), .vld_o(vld_hi));
			posit_lod #(.W(W/2)) u_lo (.in_i(in_i[W/2-1:0]), .pos_o(pos_lo), .vld_o(vld_lo));

			// Upper half wins, else offset by W/2
			assign vld_o = vld_hi | vld_lo;
			assign pos_o = vld_hi ? {1'b0, pos_hi} : {vld_lo, pos_lo};
		end
	endgenerate

endmodule

// ==== logic/posit_decoder.sv ====
`timescale 1ns/1ps
`include "posit_config.svh"

// Splits one posit word into sign, regime, exponent, mantissa
module posit_decoder (
	input  posit_pkg::posit_t     word_i,
	output posit_pkg::posit_dec_t dec_o
);

	logic [`POSIT_N-1:0]  mag;      // Absolute value
	logic                 rc;       // First regime bit
	logic [`POSIT_N-1:0]  run_scan; // Regime run as leading zeros
	logic [`POSIT_BS-1:0] run_len;
	logic                 run_vld;
	logic [`POSIT_N-1:0]  shifted;

	//////////////////////////////////////////////////
	// Magnitude and regime run
	//////////////////////////////////////////////////

	assign mag = word_i[`POSIT_N-1] ? -word_i : word_i;
	assign rc  = mag[`POSIT_N-2];

	// Ones run inverted into zeros
	// Appended 1 stops an all-ones run at maxpos
	assign run_scan = rc ? {~mag[`POSIT_N-2:0], 1'b1} : {mag[`POSIT_N-2:0], 1'b0};

	posit_lod #(.W(`POSIT_N)) u_lod (
		.in_i  (run_scan),
		.pos_o (run_len),  // Length of the run
		.vld_o (run_vld)   // Low only for 0 and NaR
	);

	// Drop the first regime bit, then the rest of the run and terminator
	assign shifted = {mag[`POSIT_N-3:0], 2'b00} << run_len;

	//////////////////////////////////////////////////
	// Fields
	//////////////////////////////////////////////////

	assign dec_o.sign   = word_i[`POSIT_N-1];
	assign dec_o.nar    = word_i[`POSIT_N-1] & ~run_vld;
	assign dec_o.zero   = ~word_i[`POSIT_N-1] & ~run_vld;
	assign dec_o.rpos   = rc;
	assign dec_o.regime = rc ? run_len - 1'b1 : run_len; // k = run-1 for ones
	assign dec_o.exp    = shifted[`POSIT_N-1:`POSIT_N-`POSIT_ES];
	assign dec_o.mant   = {run_vld, shifted[`POSIT_N-`POSIT_ES-1:0]}; // Hidden bit

endmodule

// ==== logic/posit_mant_mult.sv ====
`timescale 1ns/1ps
`include "posit_config.svh"

// Mantissa product, normalization and scale sum
module posit_mant_mult (
	input  posit_pkg::posit_dec_t a_i,
	input  posit_pkg::posit_dec_t b_i,
	output posit_mult_pkg::prod_t prod_o
);

	import posit_mult_pkg::*;

	logic [2*(`POSIT_N-`POSIT_ES+1)-1:0] mant_raw;
	logic [2*(`POSIT_N-`POSIT_ES+1)-1:0] mant_norm;
	logic                                ovf;     // Product in [2,4)
	scale_t                              scale_a;
	scale_t                              scale_b;

	// Signed 4*k + e from regime count and exponent
	function automatic scale_t to_scale(
		input logic                 rpos,
		input logic [`POSIT_BS-1:0] regime,
		input logic [`POSIT_ES-1:0] exp
	);
		logic signed [`POSIT_BS+1:0] k;
		k = rpos ? {2'b00, regime} : -{2'b00, regime};
		return {k, exp};
	endfunction

	//////////////////////////////////////////////////
	// Mantissa
	//////////////////////////////////////////////////

	assign mant_raw  = a_i.mant * b_i.mant;
	assign ovf       = mant_raw[$high(mant_raw)];
	assign mant_norm = ovf ? mant_raw : mant_raw << 1; // Hidden one to MSB

	//////////////////////////////////////////////////
	// Scale, sign, specials
	//////////////////////////////////////////////////

	assign scale_a = to_scale(a_i.rpos, a_i.regime, a_i.exp);
	assign scale_b = to_scale(b_i.rpos, b_i.regime, b_i.exp);

	assign prod_o.scale = scale_a + scale_b + scale_t'(ovf); // Carry from overflow
	assign prod_o.mant  = mant_norm;
	assign prod_o.norm  = mant_norm[$high(mant_norm)];
	assign prod_o.sign  = a_i.sign ^ b_i.sign;
	assign prod_o.nar   = a_i.nar | b_i.nar;
	assign prod_o.zero  = a_i.zero & b_i.zero; // Both must be zero

endmodule

// ==== logic/posit_encoder.sv ====
`timescale 1ns/1ps
`include "posit_config.svh"

// Packs scale and mantissa back into a posit word, round to nearest even
module posit_encoder (
	input  posit_mult_pkg::prod_t     prod_i,
	output posit_mult_pkg::mult_out_t res_o
);

	import posit_mult_pkg::*;

	localparam int N  = `POSIT_N;
	localparam int PW = 2 * (`POSIT_N - `POSIT_ES + 1); // Product width

	scale_t                       scale;
	logic                         neg;       // Scale below zero
	logic [`POSIT_BS+`POSIT_ES:0] scale_mag;
	logic [`POSIT_ES-1:0]         exp_o;
	logic [`POSIT_BS:0]           run;       // Regime bits incl. terminator pos
	logic [`POSIT_BS-1:0]         shamt;
	logic [2*N+2:0]               pattern;
	logic [3*N+2:0]               shifted;
	logic [N-1:0]                 window;    // Result bits plus guard at bit 0
	logic                         lsb;
	logic                         guard;
	logic                         rnd;
	logic                         sticky;
	logic                         ulp;
	logic [N-1:0]                 rounded;
	logic [N-1:0]                 mag_word;
	logic [N-1:0]                 signed_word;

	//////////////////////////////////////////////////
	// Scale to regime run and exponent
	//////////////////////////////////////////////////

	assign scale     = prod_i.scale;
	assign neg       = scale[$high(scale)];
	assign scale_mag = neg ? -scale[`POSIT_BS+`POSIT_ES:0] : scale[`POSIT_BS+`POSIT_ES:0];
	assign exp_o     = scale[`POSIT_ES-1:0]; // Two's complement low bits

	// Positive k needs k+1 ones, negative needs -k zeros
	assign run = (!neg || |scale_mag[`POSIT_ES-1:0])
		? scale_mag[`POSIT_BS+`POSIT_ES:`POSIT_ES] + 1'b1
		: scale_mag[`POSIT_BS+`POSIT_ES:`POSIT_ES];
	assign shamt = run[`POSIT_BS] ? '1 : run[`POSIT_BS-1:0]; // Saturate at word

	//////////////////////////////////////////////////
	// Regime, exponent, fraction, G R S
	//////////////////////////////////////////////////

	// Run fill on top, opposite bit is the terminator
	assign pattern = {{N{~neg}}, neg, exp_o, prod_i.mant[PW-2:PW-N],
		|prod_i.mant[PW-N-1:0]};
	assign shifted = {pattern, {N{1'b0}}} >> shamt;
	assign window  = shifted[2*N+2:N+3];

	assign lsb    = shifted[N+4];
	assign guard  = shifted[N+3];
	assign rnd    = shifted[N+2];
	assign sticky = |shifted[N+1:0];
	assign ulp    = guard & (lsb | rnd | sticky); // Ties go to even

	// Long regime leaves no room to round
	assign rounded = (run < N - `POSIT_ES - 2) ? window + {{(N-1){1'b0}}, ulp} : window;

	//////////////////////////////////////////////////
	// Sign and specials
	//////////////////////////////////////////////////

	assign mag_word    = {1'b0, rounded[N-1:1]}; // Guard dropped
	assign signed_word = prod_i.sign ? -mag_word : mag_word;

	assign res_o.word = (prod_i.nar | prod_i.zero | ~prod_i.norm)
		? {prod_i.nar, {(N-1){1'b0}}}
		: signed_word;
	assign res_o.nar  = prod_i.nar;
	assign res_o.zero = prod_i.zero;

endmodule

// ==== logic/posit_mult_top.sv ====
`timescale 1ns/1ps
`include "posit_config.svh"

// Registered posit multiplier
module posit_mult_top (
	input  logic              Clk,
	input  logic              rst,
	input  logic              start_i, // Operand pair valid
	input  posit_pkg::posit_t a_i,
	input  posit_pkg::posit_t b_i,
	output posit_pkg::posit_t p_o,
	output logic              nar_o,
	output logic              zero_o,
	output logic              done_o   // start_i, two stages on
);

	import posit_pkg::*;
	import posit_mult_pkg::*;

	posit_t     a_q;
	posit_t     b_q;
	logic       start_q;
	posit_dec_t dec_a;
	posit_dec_t dec_b;
	prod_t      prod;
	mult_out_t  res;
	mult_out_t  res_q;
	logic       done_q;

	//////////////////////////////////////////////////
	// Input bank
	//////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			a_q     <= '0;
			b_q     <= '0;
			start_q <= 1'b0;
		end else begin
			a_q     <= a_i;
			b_q     <= b_i;
			start_q <= start_i;
		end
	end

	// Combinational datapath
	posit_decoder   u_dec_a  (.word_i(a_q), .dec_o(dec_a));
	posit_decoder   u_dec_b  (.word_i(b_q), .dec_o(dec_b));
	posit_mant_mult u_mult   (.a_i(dec_a), .b_i(dec_b), .prod_o(prod));
	posit_encoder   u_encode (.prod_i(prod), .res_o(res));

	//////////////////////////////////////////////////
	// Output bank
	//////////////////////////////////////////////////

	always_ff @(posedge Clk) begin
		if (rst) begin
			res_q  <= '0;
			done_q <= 1'b0;
		end else begin
			res_q  <= res;     // Overwritten every cycle
			done_q <= start_q;
		end
	end

	assign p_o    = res_q.word;
	assign nar_o  = res_q.nar;
	assign zero_o = res_q.zero;
	assign done_o = done_q;

endmodule

// ==== dv/posit_mult_assertions.sv ====
`timescale 1ns/1ps
`include "posit_config.svh"

// Protocol and flag checks, bound into the multiplier top
module posit_mult_assertions (
	input logic              Clk,
	input logic              rst,
	input logic              start_i,
	input posit_pkg::posit_t p_i,
	input logic              nar_i,
	input logic              zero_i,
	input logic              done_i
);

	//////////////////////////////////////////////////
	// Strobe
	//////////////////////////////////////////////////

	a_done_reset: assert property (@(posedge Clk) rst |=> !done_i)
		else $error("done_o high after a reset cycle");

	// Two register stages between start and done
	a_done_delay: assert property (@(posedge Clk) disable iff (rst)
		done_i == $past(start_i, 2))
		else $error("done_o does not follow start_i two edges later");

	//////////////////////////////////////////////////
	// Flags against the word
	//////////////////////////////////////////////////

	a_nar_word: assert property (@(posedge Clk)
		nar_i |-> p_i == {1'b1, {(`POSIT_N-1){1'b0}}})
		else $error("nar_o set with a word other than NaR");

	a_zero_word: assert property (@(posedge Clk) zero_i |-> p_i == '0)
		else $error("zero_o set with a nonzero word");

endmodule

bind posit_mult_top posit_mult_assertions u_assertions (
	.Clk(Clk), .rst(rst), .start_i(start_i), .p_i(p_o),
	.nar_i(nar_o), .zero_i(zero_o), .done_i(done_o)
);

// ==== dv/posit_mult_tb.sv ====
`timescale 1ns/1ps

// Table and LCG driven testbench for the posit multiplier
module posit_mult_tb;

	import posit_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int NTAB         = 11;
	localparam int NRAND        = 24;
	localparam int OPS_PER_DRAW = 8; // Identity 2, commute and sign 3, specials 3
	localparam int OP_CYCLES    = 4; // Negedges spent in one run_op
	// Reset, table, random draws, back to back pair, margin
	localparam int CYCLE_LIMIT  = RESET_CYCLES
		+ OP_CYCLES * (NTAB + OPS_PER_DRAW * NRAND + 2) + 32;
	localparam posit_t ONE = 32'h4000_0000;
	localparam posit_t NAR = 32'h8000_0000;

	typedef struct packed {
		posit_t a;
		posit_t b;
		posit_t p;    // Expected word
		logic   nar;
		logic   zero;
	} vec_t;

	typedef struct packed {
		posit_t p;
		logic   nar;
		logic   zero;
	} result_t;

	logic        Clk = 1'b0;
	logic        rst;
	logic        start_i;
	posit_t      a_i;
	posit_t      b_i;
	posit_t      p_o;
	logic        nar_o;
	logic        zero_o;
	logic        done_o;
	logic [31:0] lcg_state = 32'd78;
	int          cycles    = 0;
	int          test_errs = 0; // Mismatches in the running test
	int          n_pass    = 0;
	int          n_fail    = 0;

	//////////////////////////////////////////////////
	// Directed table
	//////////////////////////////////////////////////

	// 1.0 = 4000_0000, 2.0 = 4800_0000, 4.0 = 5000_0000, 0.5 = 3800_0000
	vec_t vecs [NTAB] = '{
		'{32'h4800_0000, 32'h4800_0000, 32'h5000_0000, 1'b0, 1'b0},
		'{32'h3800_0000, 32'h4800_0000, 32'h4000_0000, 1'b0, 1'b0},
		'{32'h4000_0000, 32'h4000_0000, 32'h4000_0000, 1'b0, 1'b0},
		'{32'hB800_0000, 32'h4800_0000, 32'hB000_0000, 1'b0, 1'b0}, // -(4.0)
		'{32'h3800_0000, 32'hB800_0000, 32'hC000_0000, 1'b0, 1'b0}, // -(1.0)
		'{32'hC000_0000, 32'h4000_0000, 32'hC000_0000, 1'b0, 1'b0},
		'{32'h8000_0000, 32'h4000_0000, 32'h8000_0000, 1'b1, 1'b0},
		'{32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1'b1, 1'b0}, // NaR beats zero
		'{32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1},
		'{32'h0000_0000, 32'h4800_0000, 32'h0000_0000, 1'b0, 1'b0}, // One zero only
		'{32'h5000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0}
	};
	string names [NTAB] = '{"two_x_two", "half_x_two", "one_x_one", "neg_two_x_two",
		"half_x_neg_two", "neg_one_x_one", "nar_x_one", "zero_x_nar", "zero_x_zero",
		"zero_x_two", "four_x_zero"};

	posit_mult_top u_posit_mult_top (
		.Clk(Clk), .rst(rst), .start_i(start_i), .a_i(a_i), .b_i(b_i),
		.p_o(p_o), .nar_o(nar_o), .zero_o(zero_o), .done_o(done_o)
	);

	always #50 Clk = ~Clk; // 100 ns period

	// Watchdog
	always @(posedge Clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Wraps at 2^32
		return lcg_state;
	endfunction

	// Never zero or NaR
	function automatic posit_t random_posit();
		posit_t x;
		x = lcg_next();
		while (x == '0 || x == NAR)
			x = lcg_next();
		return x;
	endfunction

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("** Error %s: %s expected %h, actual %h", name, what, expected, actual);
			test_errs++;
		end
	endtask

	task automatic check_result(input string name, input posit_t p, input logic nar,
		input logic zero, input result_t act);
		check_value(name, "p_o", p, act.p);
		check_value(name, "nar_o", {31'd0, nar}, {31'd0, act.nar});
		check_value(name, "zero_o", {31'd0, zero}, {31'd0, act.zero});
	endtask

	// One strobe in, wait for its done, grab the result
	task automatic run_op(input string name, input posit_t a, input posit_t b,
		output result_t r);
		@(negedge Clk);
		start_i = 1'b1;
		a_i     = a;
		b_i     = b;
		@(negedge Clk);
		start_i = 1'b0;
		while (!done_o)
			@(negedge Clk);
		r = '{p_o, nar_o, zero_o};
		@(negedge Clk);
		check_value(name, "done_o one cycle later", 32'd0, {31'd0, done_o}); // Single done
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			n_pass++;
			$display("PASS  %s", name);
		end else begin
			n_fail++;
			$display("FAIL  %s, %0d mismatches", name, test_errs);
		end
		test_errs = 0;
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		result_t r;
		result_t r_ab;
		result_t r_ba;
		posit_t  x;
		posit_t  y;
		rst     = 1'b1;
		start_i = 1'b0;
		a_i     = '0;
		b_i     = '0;
		repeat (RESET_CYCLES) @(negedge Clk);
		rst = 1'b0;
		r   = '{p_o, nar_o, zero_o}; // Still the reset values
		check_result("reset_state", '0, 1'b0, 1'b0, r);
		check_value("reset_state", "done_o", 32'd0, {31'd0, done_o});
		finish_test("reset_state");

		for (int i = 0; i < NTAB; i++) begin
			run_op(names[i], vecs[i].a, vecs[i].b, r);
			check_result(names[i], vecs[i].p, vecs[i].nar, vecs[i].zero, r);
			finish_test(names[i]);
		end

		for (int i = 0; i < NRAND; i++) begin
			x = random_posit();
			run_op("identity", x, ONE, r);
			check_result("identity", x, 1'b0, 1'b0, r);
			run_op("identity", ONE, x, r);
			check_result("identity", x, 1'b0, 1'b0, r);
		end
		finish_test("identity");

		// Relations between separate starts
		for (int i = 0; i < NRAND; i++) begin
			x = random_posit();
			y = random_posit();
			run_op("commute_sign", x, y, r_ab);
			run_op("commute_sign", y, x, r_ba);
			run_op("commute_sign", -x, y, r);
			check_result("commute_sign", r_ab.p, 1'b0, 1'b0, r_ba);
			check_result("commute_sign", -r_ab.p, 1'b0, 1'b0, r);
		end
		finish_test("commute_sign");

		for (int i = 0; i < NRAND; i++) begin
			x = random_posit();
			run_op("specials", NAR, x, r);
			check_result("specials", NAR, 1'b1, 1'b0, r);
			run_op("specials", x, NAR, r);
			check_result("specials", NAR, 1'b1, 1'b0, r);
			run_op("specials", '0, x, r);
			check_result("specials", '0, 1'b0, 1'b0, r); // zero_o needs both zero
		end
		finish_test("specials");

		// Two starts in a row
		@(negedge Clk);
		start_i = 1'b1;
		a_i     = 32'h4800_0000; // 2.0 x 2.0
		b_i     = 32'h4800_0000;
		@(negedge Clk);
		a_i     = 32'h3800_0000; // 0.5 x 2.0
		@(negedge Clk);
		start_i = 1'b0;
		while (!done_o)
			@(negedge Clk);
		r = '{p_o, nar_o, zero_o};
		check_result("back_to_back", 32'h5000_0000, 1'b0, 1'b0, r);
		@(negedge Clk);
		check_value("back_to_back", "second done_o", 32'd1, {31'd0, done_o});
		r = '{p_o, nar_o, zero_o};
		check_result("back_to_back", 32'h4000_0000, 1'b0, 1'b0, r);
		@(negedge Clk);
		check_value("back_to_back", "done_o after pair", 32'd0, {31'd0, done_o});
		finish_test("back_to_back");

		$display("Summary: %0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== posit_mult_top.f ====
+incdir+logic
logic/posit_pkg.sv
logic/posit_mult_pkg.sv
logic/posit_lod.sv
logic/posit_decoder.sv
logic/posit_mant_mult.sv
logic/posit_encoder.sv
logic/posit_mult_top.sv
dv/posit_mult_assertions.sv
dv/posit_mult_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= posit_mult_tb
FILELIST  ?= posit_mult_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
